// ==== files.f ====
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_control.sv
source/pipeline_trace.sv
source/cpu_core.sv
dv/clock_gen.sv
dv/cpu_tb.sv

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam int PROG_LEN     = 200;
    localparam int PROLOGUE_LEN = 15;                      // Seven register inits, eight stores
    localparam int RESET_CYCLES = 16;
    localparam int RETIRE_COUNT = 600;
    localparam int CYCLE_LIMIT  = 4 * RETIRE_COUNT + 200;  // Worst stall per retire plus slack

    logic                clk;
    logic                rst;
    logic                imem_we;
    cpu_pkg::pc_t        imem_addr;
    cpu_pkg::instr_t     imem_wdata;
    logic                retire_valid;
    cpu_pkg::seq_t       retire_seq;
    cpu_pkg::pc_t        retire_pc;
    cpu_pkg::instr_t     retire_instr;
    logic                retire_wen;
    cpu_pkg::reg_idx_t   retire_rd;
    cpu_pkg::word_t      retire_data;
    cpu_pkg::stamp_t     retire_fetch_cycle, retire_decode_cycle, retire_execute_cycle;
    cpu_pkg::stamp_t     retire_memory_cycle, retire_wb_cycle;

    cpu_pkg::instr_t     prog [PROG_LEN];
    cpu_pkg::word_t      m_rf [8];                         // ISA model registers
    cpu_pkg::word_t      m_mem [cpu_pkg::DMEM_DEPTH];      // ISA model data memory
    cpu_pkg::pc_t        m_pc;
    logic                hist_wen [3];                     // Writers of the last three retires
    cpu_pkg::reg_idx_t   hist_rd [3];                      // Newest first
    cpu_pkg::pc_t        exp_pc;                           // Expected retire record
    cpu_pkg::instr_t     exp_instr;
    logic                exp_wen, exp_taken, exp_dep, exp_hazard;
    cpu_pkg::reg_idx_t   exp_rd;
    cpu_pkg::word_t      exp_data;
    cpu_pkg::seq_t       exp_seq;
    int                  retired;
    int                  run_cycles;

    clock_gen #(.PERIOD_NS(8.0)) i_clock_gen (.clk(clk));

    cpu_core i_cpu_core (.*);

    ////////////////////////////////////////
    // Failure exit and compare tasks
    ////////////////////////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic word_check(input cpu_pkg::word_t got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR @ %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic pc_check(input cpu_pkg::pc_t got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR @ %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic instr_check(input cpu_pkg::instr_t got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR @ %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic seq_check(input cpu_pkg::seq_t got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR @ %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic rd_check(input cpu_pkg::reg_idx_t got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR @ %0t: %s is r%0d, expected r%0d",
                                $time, what, got, exp));
    endtask

    task automatic flag_check(input logic got, exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR @ %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // Stamp must fall inside [lo, hi]
    task automatic stamp_check(input cpu_pkg::stamp_t got, lo, hi, input string what);
        if (got < lo || got > hi)
            abort_run($sformatf("ERROR @ %0t: %s is %0d, expected %0d to %0d",
                                $time, what, got, lo, hi));
    endtask

    ////////////////////////////////////////
    // Program generator
    ////////////////////////////////////////
    function automatic cpu_pkg::instr_t encode(input cpu_pkg::opcode_e op,
                                               input cpu_pkg::reg_idx_t rd,
                                               input cpu_pkg::reg_idx_t rs1,
                                               input logic [5:0] low);
        return {op, rd, rs1, low};
    endfunction

    task automatic build_program();
        int                k;
        int                reach;
        cpu_pkg::reg_idx_t rd;
        for (k = 1; k < 8; k++)                            // Known value in every register
            prog[k-1] = encode(cpu_pkg::OP_ADDI, cpu_pkg::reg_idx_t'(k), '0, 6'($urandom));
        for (k = 0; k < 8; k++)                            // Fill the load window 0..7
            prog[7+k] = encode(cpu_pkg::OP_SW, cpu_pkg::reg_idx_t'(k), '0, 6'(k));
        for (k = PROLOGUE_LEN; k < PROG_LEN - 1; k++) begin
            rd = cpu_pkg::reg_idx_t'($urandom);
            case ($urandom % 10)
                0, 1, 2, 3: prog[k] = encode(cpu_pkg::opcode_e'(1 + $urandom % 4), rd,
                                             cpu_pkg::reg_idx_t'($urandom), {3'($urandom), 3'b000});
                4, 5: prog[k] = encode(cpu_pkg::OP_ADDI, rd, cpu_pkg::reg_idx_t'($urandom),
                                       6'($urandom));
                6:    prog[k] = encode(cpu_pkg::OP_LW, rd, '0, 6'($urandom % 8));
                7:    prog[k] = encode(cpu_pkg::OP_SW, rd, '0, 6'($urandom % 8));
                8: begin
                    reach   = (PROG_LEN - 2 - k < 31) ? PROG_LEN - 2 - k : 31;  // Stay in program
                    prog[k] = encode(cpu_pkg::OP_BEQ, rd,
                                     ($urandom % 2) ? rd : cpu_pkg::reg_idx_t'($urandom),
                                     6'($urandom % (reach + 1)));   // Half always taken
                end
                default: prog[k] = '0;                     // NOP
            endcase
        end
        prog[PROG_LEN-1] = encode(cpu_pkg::OP_BEQ, '0, '0, 6'h3f);  // Spins on itself
    endtask

    ////////////////////////////////////////
    // ISA reference model stepping one retire per call
    ////////////////////////////////////////
    // Source registers of each operation
    function automatic logic reads_reg(input cpu_pkg::opcode_e op, input cpu_pkg::reg_idx_t rd,
                                       input cpu_pkg::reg_idx_t rs1,
                                       input cpu_pkg::reg_idx_t rs2,
                                       input cpu_pkg::reg_idx_t r);
        case (op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
            cpu_pkg::OP_AND, cpu_pkg::OP_OR:  return (rs1 == r) || (rs2 == r);
            cpu_pkg::OP_ADDI, cpu_pkg::OP_LW: return rs1 == r;
            cpu_pkg::OP_SW, cpu_pkg::OP_BEQ:  return (rs1 == r) || (rd == r);
            default:                          return 1'b0;
        endcase
    endfunction

    task automatic model_step();
        cpu_pkg::instr_t   ins;
        cpu_pkg::opcode_e  op;
        cpu_pkg::reg_idx_t rd, rs1, rs2;
        cpu_pkg::word_t    imm, a, ea;
        int                k;
        ins = prog[m_pc];
        op  = cpu_pkg::opcode_e'(ins[15:12]);
        rd  = ins[11:9];
        rs1 = ins[8:6];
        rs2 = ins[5:3];
        imm = {{10{ins[5]}}, ins[5:0]};
        a   = m_rf[rs1];
        ea  = a + imm;                                     // LW/SW effective address
        exp_pc    = m_pc;
        exp_instr = ins;
        exp_rd    = rd;
        exp_data  = '0;
        exp_taken = 1'b0;
        m_pc      = m_pc + 8'd1;
        case (op)
            cpu_pkg::OP_ADD:  exp_data = a + m_rf[rs2];
            cpu_pkg::OP_SUB:  exp_data = a - m_rf[rs2];
            cpu_pkg::OP_AND:  exp_data = a & m_rf[rs2];
            cpu_pkg::OP_OR:   exp_data = a | m_rf[rs2];
            cpu_pkg::OP_ADDI: exp_data = ea;
            cpu_pkg::OP_LW:   exp_data = m_mem[ea % cpu_pkg::DMEM_DEPTH];
            cpu_pkg::OP_SW:   m_mem[ea % cpu_pkg::DMEM_DEPTH] = m_rf[rd];
            cpu_pkg::OP_BEQ: begin
                exp_taken = (m_rf[rd] == a);
                if (exp_taken) m_pc = exp_pc + 8'd1 + imm[7:0];
            end
            default: ;
        endcase
        // Older writers that can still sit in execute, memory or write-back
        exp_dep    = hist_wen[0] && reads_reg(op, rd, rs1, rs2, hist_rd[0]);
        exp_hazard = exp_dep;
        for (k = 1; k < 3; k++) begin
            if (hist_wen[k] && reads_reg(op, rd, rs1, rs2, hist_rd[k])) exp_hazard = 1'b1;
        end
        exp_wen = (op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                              cpu_pkg::OP_ADDI, cpu_pkg::OP_LW}) && rd != '0;  // r0 never written
        if (exp_wen) m_rf[rd] = exp_data;
        for (k = 2; k > 0; k--) begin
            hist_wen[k] = hist_wen[k-1];
            hist_rd[k]  = hist_rd[k-1];
        end
        hist_wen[0] = exp_wen;
        hist_rd[0]  = rd;
    endtask

    task automatic record_check();
        cpu_pkg::stamp_t f, d, e, m, w;
        f = retire_fetch_cycle;
        d = retire_decode_cycle;
        e = retire_execute_cycle;
        m = retire_memory_cycle;
        w = retire_wb_cycle;
        seq_check(retire_seq, exp_seq, "retire_seq");
        pc_check(retire_pc, exp_pc, "retire_pc");
        instr_check(retire_instr, exp_instr, "retire_instr");
        flag_check(retire_wen, exp_wen, "retire_wen");
        if (exp_wen) begin
            rd_check(retire_rd, exp_rd, "retire_rd");
            word_check(retire_data, exp_data, "retire_data");
        end
        stamp_check(d, f + 16'd1, '1, "decode stamp");     // Strictly increasing stages
        stamp_check(e, d + 16'd1, '1, "execute stamp");
        stamp_check(m, e + 16'd1, '1, "memory stamp");
        stamp_check(w, m + 16'd1, '1, "write-back stamp");
        stamp_check(w, f + 16'd4, '1, "fetch to write-back span");
        if (!exp_hazard)
            stamp_check(w, f + 16'd4, f + 16'd4, "unstalled span");   // No older writer feeds it
        if (exp_dep)
            stamp_check(w, f + 16'd5, '1, "dependent span");   // Must have waited on producer
        exp_seq = exp_seq + (exp_taken ? 8'd3 : 8'd1);      // Two flushed tags after a branch
    endtask

    ////////////////////////////////////////
    // Stimulus and retire monitor
    ////////////////////////////////////////
    initial begin
        void'($urandom(32'hb39d_b038));
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        retired    = 0;
        run_cycles = 0;
        m_pc       = '0;
        exp_seq    = '0;
        foreach (hist_wen[i]) hist_wen[i] = 1'b0;
        foreach (hist_rd[i]) hist_rd[i] = '0;
        foreach (m_rf[i]) m_rf[i] = '0;
        foreach (m_mem[i]) m_mem[i] = '0;
        build_program();
        // Reset covers the program load and RESET_CYCLES more
        for (int n = 0; n < PROG_LEN; n++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = cpu_pkg::pc_t'(n);
            imem_wdata = prog[n];
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        while (retired < RETIRE_COUNT) begin
            do @(negedge clk); while (retire_valid !== 1'b1);  // Record is stable mid-cycle
            model_step();
            record_check();
            retired++;
        end
        $display("Finished with no errors");
        $finish;
    end

    // Run limit counted from reset release
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            run_cycles++;
            if (run_cycles > CYCLE_LIMIT)
                abort_run($sformatf("Timeout: only %0d of %0d instructions retired in %0d cycles",
                                    retired, RETIRE_COUNT, CYCLE_LIMIT));
        end
    end

endmodule

// ==== dv/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;   // Free running, 50% duty

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
    parameter int IMEM_DEPTH  = cpu_pkg::IMEM_DEPTH,
    parameter int DMEM_DEPTH  = cpu_pkg::DMEM_DEPTH,
    parameter int TRACE_DEPTH = cpu_pkg::TRACE_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                imem_we,
    input  cpu_pkg::pc_t        imem_addr,
    input  cpu_pkg::instr_t     imem_wdata,
    output logic                retire_valid,
    output cpu_pkg::seq_t       retire_seq,
    output cpu_pkg::pc_t        retire_pc,
    output cpu_pkg::instr_t     retire_instr,
    output logic                retire_wen,
    output cpu_pkg::reg_idx_t   retire_rd,
    output cpu_pkg::word_t      retire_data,
    output cpu_pkg::stamp_t     retire_fetch_cycle,
    output cpu_pkg::stamp_t     retire_decode_cycle,
    output cpu_pkg::stamp_t     retire_execute_cycle,
    output cpu_pkg::stamp_t     retire_memory_cycle,
    output cpu_pkg::stamp_t     retire_wb_cycle
);

    // Control
    logic              stall_decode, flush_front;
    cpu_pkg::pc_t      redirect_pc;
    logic              branch_taken;
    cpu_pkg::pc_t      branch_target;

    // Fetch and IF/ID
    logic              fetch_valid, if_valid;
    cpu_pkg::seq_t     fetch_seq, if_seq;
    cpu_pkg::pc_t      if_pc;
    cpu_pkg::instr_t   if_instr;

    // Decode sources and ID/EX
    cpu_pkg::reg_idx_t dec_rs1, dec_rs2;
    logic              dec_uses_rs2;
    logic              id_valid, id_wen;
    cpu_pkg::seq_t     id_seq;
    cpu_pkg::pc_t      id_pc;
    cpu_pkg::instr_t   id_instr;
    cpu_pkg::opcode_e  id_op;
    cpu_pkg::reg_idx_t id_rd;
    cpu_pkg::word_t    id_a, id_b, id_store_data;

    // EX/MEM
    logic              ex_valid, ex_wen;
    cpu_pkg::seq_t     ex_seq;
    cpu_pkg::pc_t      ex_pc;
    cpu_pkg::instr_t   ex_instr;
    cpu_pkg::opcode_e  ex_op;
    cpu_pkg::reg_idx_t ex_rd;
    cpu_pkg::word_t    ex_result, ex_store_data;

    // MEM/WB, shared by register file and trace
    logic              wb_valid, wb_wen;
    cpu_pkg::seq_t     wb_seq;
    cpu_pkg::pc_t      wb_pc;
    cpu_pkg::instr_t   wb_instr;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;

    ////////////////////////////////////////
    // Pipeline stages
    ////////////////////////////////////////
    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch_stage (.*);

    decode_stage i_decode_stage (.*);

    execute_stage i_execute_stage (.*);

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) i_memory_stage (.*);

    hazard_control i_hazard_control (.*);

    // Retire trace
    pipeline_trace #(.TRACE_DEPTH(TRACE_DEPTH)) i_pipeline_trace (.*);

endmodule

// ==== source/pipeline_trace.sv ====
`timescale 1ns/1ps

module pipeline_trace #(
    parameter int TRACE_DEPTH = cpu_pkg::TRACE_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_valid,
    input  cpu_pkg::seq_t       fetch_seq,
    input  logic                if_valid,
    input  cpu_pkg::seq_t       if_seq,
    input  logic                id_valid,
    input  cpu_pkg::seq_t       id_seq,
    input  logic                ex_valid,
    input  cpu_pkg::seq_t       ex_seq,
    input  logic                wb_valid,
    input  cpu_pkg::seq_t       wb_seq,
    input  cpu_pkg::pc_t        wb_pc,
    input  cpu_pkg::instr_t     wb_instr,
    input  logic                wb_wen,
    input  cpu_pkg::reg_idx_t   wb_rd,
    input  cpu_pkg::word_t      wb_data,
    output logic                retire_valid,
    output cpu_pkg::seq_t       retire_seq,
    output cpu_pkg::pc_t        retire_pc,
    output cpu_pkg::instr_t     retire_instr,
    output logic                retire_wen,
    output cpu_pkg::reg_idx_t   retire_rd,
    output cpu_pkg::word_t      retire_data,
    output cpu_pkg::stamp_t     retire_fetch_cycle,
    output cpu_pkg::stamp_t     retire_decode_cycle,
    output cpu_pkg::stamp_t     retire_execute_cycle,
    output cpu_pkg::stamp_t     retire_memory_cycle,
    output cpu_pkg::stamp_t     retire_wb_cycle
);

    localparam int IW = $clog2(TRACE_DEPTH);

    cpu_pkg::stamp_t cycle;
    cpu_pkg::stamp_t fetch_tab [TRACE_DEPTH];   // One row per low tag bits
    cpu_pkg::stamp_t dec_tab   [TRACE_DEPTH];
    cpu_pkg::stamp_t exe_tab   [TRACE_DEPTH];
    cpu_pkg::stamp_t mem_tab   [TRACE_DEPTH];
    logic            seen_retire;

    always_ff @(posedge clk) begin
        if (rst) cycle <= '0;
        else     cycle <= cycle + 1'b1;
    end

    ////////////////////////////////////////
    // Stamp table, last occupied cycle wins
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (fetch_valid) fetch_tab[fetch_seq[IW-1:0]] <= cycle;
        if (if_valid)    dec_tab[if_seq[IW-1:0]]      <= cycle;   // IF/ID = decode
        if (id_valid)    exe_tab[id_seq[IW-1:0]]      <= cycle;   // ID/EX = execute
        if (ex_valid)    mem_tab[ex_seq[IW-1:0]]      <= cycle;   // EX/MEM = memory
    end

    // Retire record
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            seen_retire  <= 1'b0;
        end else begin
            retire_valid <= wb_valid;
            seen_retire  <= seen_retire || wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            retire_seq           <= wb_seq;
            retire_pc            <= wb_pc;
            retire_instr         <= wb_instr;
            retire_wen           <= wb_wen;
            retire_rd            <= wb_rd;
            retire_data          <= wb_data;
            retire_fetch_cycle   <= fetch_tab[wb_seq[IW-1:0]];
            retire_decode_cycle  <= dec_tab[wb_seq[IW-1:0]];
            retire_execute_cycle <= exe_tab[wb_seq[IW-1:0]];
            retire_memory_cycle  <= mem_tab[wb_seq[IW-1:0]];
            retire_wb_cycle      <= cycle;                      // Write-back is now
        end
    end

    // Tags retire in fetch order, gaps only from flushed slots
    a_seq_order: assert property (@(posedge clk) disable iff (rst)
        wb_valid && seen_retire |->
            cpu_pkg::seq_t'(wb_seq - retire_seq) != '0 &&
            cpu_pkg::seq_t'(wb_seq - retire_seq) < 8'd128);

endmodule

// ==== source/hazard_control.sv ====
`timescale 1ns/1ps

module hazard_control (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::reg_idx_t   dec_rs1,
    input  cpu_pkg::reg_idx_t   dec_rs2,
    input  logic                dec_uses_rs2,
    input  logic                if_valid,
    input  logic                id_valid,
    input  cpu_pkg::reg_idx_t   id_rd,
    input  logic                id_wen,
    input  logic                ex_valid,
    input  cpu_pkg::reg_idx_t   ex_rd,
    input  logic                ex_wen,
    input  logic                wb_valid,
    input  cpu_pkg::reg_idx_t   wb_rd,
    input  logic                wb_wen,
    input  logic                branch_taken,
    input  cpu_pkg::pc_t        branch_target,
    output logic                stall_decode,
    output logic                flush_front,
    output cpu_pkg::pc_t        redirect_pc
);

    cpu_pkg::ctrl_state_e state;
    logic                 raw_hit;

    // Does an older writer target one of the decode sources
    function automatic logic writes_src(input logic vld, input logic wen,
                                        input cpu_pkg::reg_idx_t rd);
        return vld && wen && rd != '0 &&
               (rd == dec_rs1 || (dec_uses_rs2 && rd == dec_rs2));
    endfunction

    always_comb begin
        raw_hit = if_valid && (writes_src(id_valid, id_wen, id_rd) ||
                               writes_src(ex_valid, ex_wen, ex_rd) ||
                               writes_src(wb_valid, wb_wen, wb_rd));
    end

    assign flush_front  = branch_taken;
    assign redirect_pc  = branch_target;
    assign stall_decode = raw_hit && !branch_taken;   // Flush wins

    ////////////////////////////////////////
    // Previous-cycle record
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)               state <= cpu_pkg::RUN;
        else if (flush_front)  state <= cpu_pkg::REDIRECT;
        else if (stall_decode) state <= cpu_pkg::LOAD_STALL;
        else                   state <= cpu_pkg::RUN;
    end

    // The slot emptied by a flush is never held on the next cycle
    a_no_stall_after_flush: assert property (@(posedge clk) disable iff (rst)
        state == cpu_pkg::REDIRECT |-> !stall_decode);

    // A flush leaves IF/ID empty on the next cycle
    a_flush_clears_ifid: assert property (@(posedge clk) disable iff (rst)
        flush_front |=> !if_valid);

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage #(
    parameter int DMEM_DEPTH = cpu_pkg::DMEM_DEPTH
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_valid,
    input  cpu_pkg::seq_t       ex_seq,
    input  cpu_pkg::pc_t        ex_pc,
    input  cpu_pkg::instr_t     ex_instr,
    input  cpu_pkg::opcode_e    ex_op,
    input  cpu_pkg::reg_idx_t   ex_rd,
    input  logic                ex_wen,
    input  cpu_pkg::word_t      ex_result,
    input  cpu_pkg::word_t      ex_store_data,
    output logic                wb_valid,
    output cpu_pkg::seq_t       wb_seq,
    output cpu_pkg::pc_t        wb_pc,
    output cpu_pkg::instr_t     wb_instr,
    output logic                wb_wen,
    output cpu_pkg::reg_idx_t   wb_rd,
    output cpu_pkg::word_t      wb_data
);

    localparam int DW = $clog2(DMEM_DEPTH);

    cpu_pkg::word_t   dmem [DMEM_DEPTH];
    logic [DW-1:0]    addr;

    assign addr = ex_result[DW-1:0];   // Wraps at the memory depth

    always_ff @(posedge clk) begin
        if (ex_valid && ex_op == cpu_pkg::OP_SW) dmem[addr] <= ex_store_data;
    end

    ////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_wen   <= ex_valid && ex_wen;   // Feeds the register file directly
        end
    end

    always_ff @(posedge clk) begin
        wb_seq   <= ex_seq;
        wb_pc    <= ex_pc;
        wb_instr <= ex_instr;
        wb_rd    <= ex_rd;
        wb_data  <= (ex_op == cpu_pkg::OP_LW) ? dmem[addr] : ex_result;  // Load or ALU
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                id_valid,
    input  cpu_pkg::seq_t       id_seq,
    input  cpu_pkg::pc_t        id_pc,
    input  cpu_pkg::instr_t     id_instr,
    input  cpu_pkg::opcode_e    id_op,
    input  cpu_pkg::reg_idx_t   id_rd,
    input  logic                id_wen,
    input  cpu_pkg::word_t      id_a,
    input  cpu_pkg::word_t      id_b,
    input  cpu_pkg::word_t      id_store_data,
    output logic                ex_valid,
    output cpu_pkg::seq_t       ex_seq,
    output cpu_pkg::pc_t        ex_pc,
    output cpu_pkg::instr_t     ex_instr,
    output cpu_pkg::opcode_e    ex_op,
    output cpu_pkg::reg_idx_t   ex_rd,
    output logic                ex_wen,
    output cpu_pkg::word_t      ex_result,
    output cpu_pkg::word_t      ex_store_data,
    output logic                branch_taken,
    output cpu_pkg::pc_t        branch_target
);

    cpu_pkg::word_t alu;

    // ALU, also forms LW/SW addresses
    always_comb begin
        case (id_op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI,
            cpu_pkg::OP_LW,  cpu_pkg::OP_SW:  alu = id_a + id_b;
            cpu_pkg::OP_SUB:                  alu = id_a - id_b;
            cpu_pkg::OP_AND:                  alu = id_a & id_b;
            cpu_pkg::OP_OR:                   alu = id_a | id_b;
            default:                          alu = '0;   // NOP, BEQ
        endcase
    end

    // BEQ compares rd with rs1, resolved here
    assign branch_taken  = id_valid && (id_op == cpu_pkg::OP_BEQ) && (id_a == id_store_data);
    assign branch_target = id_pc + 8'd1 + id_b[7:0];

    ////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) ex_valid <= 1'b0;
        else     ex_valid <= id_valid;
    end

    always_ff @(posedge clk) begin
        ex_seq        <= id_seq;
        ex_pc         <= id_pc;
        ex_instr      <= id_instr;
        ex_op         <= id_op;
        ex_rd         <= id_rd;
        ex_wen        <= id_wen;
        ex_result     <= alu;
        ex_store_data <= id_store_data;
    end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                if_valid,
    input  cpu_pkg::seq_t       if_seq,
    input  cpu_pkg::pc_t        if_pc,
    input  cpu_pkg::instr_t     if_instr,
    input  logic                stall_decode,
    input  logic                flush_front,
    input  logic                wb_wen,
    input  cpu_pkg::reg_idx_t   wb_rd,
    input  cpu_pkg::word_t      wb_data,
    output cpu_pkg::reg_idx_t   dec_rs1,
    output cpu_pkg::reg_idx_t   dec_rs2,
    output logic                dec_uses_rs2,
    output logic                id_valid,
    output cpu_pkg::seq_t       id_seq,
    output cpu_pkg::pc_t        id_pc,
    output cpu_pkg::instr_t     id_instr,
    output cpu_pkg::opcode_e    id_op,
    output cpu_pkg::reg_idx_t   id_rd,
    output logic                id_wen,
    output cpu_pkg::word_t      id_a,
    output cpu_pkg::word_t      id_b,
    output cpu_pkg::word_t      id_store_data
);

    cpu_pkg::opcode_e  op;
    cpu_pkg::reg_idx_t rd, rs1, rs2;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    rf [8];
    cpu_pkg::word_t    rd_val, rs1_val, rs2_val;
    logic              is_rtype, writes;

    ////////////////////////////////////////
    // Field split
    ////////////////////////////////////////
    assign op  = cpu_pkg::opcode_e'(if_instr[15:12]);
    assign rd  = if_instr[11:9];
    assign rs1 = if_instr[8:6];
    assign rs2 = if_instr[5:3];
    assign imm = {{10{if_instr[5]}}, if_instr[5:0]};   // Sign extend

    assign is_rtype = (op == cpu_pkg::OP_ADD) || (op == cpu_pkg::OP_SUB) ||
                      (op == cpu_pkg::OP_AND) || (op == cpu_pkg::OP_OR);
    assign writes   = is_rtype || (op == cpu_pkg::OP_ADDI) || (op == cpu_pkg::OP_LW);

    // Second source is rs2 for R-type, the rd field for SW data and BEQ compare
    assign dec_rs1      = (op == cpu_pkg::OP_NOP) ? '0 : rs1;
    assign dec_rs2      = is_rtype ? rs2 : rd;
    assign dec_uses_rs2 = is_rtype || (op == cpu_pkg::OP_SW) || (op == cpu_pkg::OP_BEQ);

    // Register file, r0 stays zero
    always_ff @(posedge clk) begin
        if (wb_wen && wb_rd != '0) rf[wb_rd] <= wb_data;
    end

    // Read ports see this cycle's write-back
    function automatic cpu_pkg::word_t read_reg(input cpu_pkg::reg_idx_t idx);
        if (idx == '0) return '0;
        if (wb_wen && wb_rd == idx) return wb_data;
        return rf[idx];
    endfunction

    always_comb begin
        rd_val  = read_reg(rd);
        rs1_val = read_reg(rs1);
        rs2_val = read_reg(rs2);
    end

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || flush_front || stall_decode) id_valid <= 1'b0;  // Clear or bubble
        else                                    id_valid <= if_valid;
    end

    always_ff @(posedge clk) begin
        id_seq        <= if_seq;
        id_pc         <= if_pc;
        id_instr      <= if_instr;
        id_op         <= op;
        id_rd         <= rd;
        id_wen        <= writes && rd != '0;   // No false hazards on r0
        id_a          <= rs1_val;
        id_b          <= is_rtype ? rs2_val : imm;
        id_store_data <= rd_val;
    end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter int IMEM_DEPTH = cpu_pkg::IMEM_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              imem_we,
    input  cpu_pkg::pc_t      imem_addr,
    input  cpu_pkg::instr_t   imem_wdata,
    input  logic              stall_decode,
    input  logic              flush_front,
    input  cpu_pkg::pc_t      redirect_pc,
    output logic              if_valid,
    output cpu_pkg::seq_t     if_seq,
    output cpu_pkg::pc_t      if_pc,
    output cpu_pkg::instr_t   if_instr,
    output logic              fetch_valid,
    output cpu_pkg::seq_t     fetch_seq
);

    localparam int AW = $clog2(IMEM_DEPTH);

    cpu_pkg::instr_t imem [IMEM_DEPTH];
    cpu_pkg::pc_t    pc;
    logic            fetch_on;   // Low for one idle cycle after reset

    // Program load, only while the core is held in reset
    always_ff @(posedge clk) begin
        if (imem_we && rst) imem[imem_addr[AW-1:0]] <= imem_wdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_on  <= 1'b0;
            pc        <= '0;
            fetch_seq <= '0;
            if_valid  <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            if (flush_front) begin           // Flush beats stall
                pc        <= redirect_pc;
                fetch_seq <= fetch_seq + 1'b1;  // Wrong-path word still burns a tag
                if_valid  <= 1'b0;
            end else if (fetch_on && !stall_decode) begin
                pc        <= pc + 1'b1;
                fetch_seq <= fetch_seq + 1'b1;
                if_valid  <= 1'b1;
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (!stall_decode) begin
            if_seq   <= fetch_seq;
            if_pc    <= pc;
            if_instr <= imem[pc[AW-1:0]];
        end
    end

    assign fetch_valid = fetch_on;

    // The load port belongs to reset time only
    a_load_in_reset: assert property (@(posedge clk) imem_we |-> rst);

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////////////////////////
    // ISA widths
    ////////////////////////////////////////
    typedef logic [15:0] word_t;     // Register and memory data
    typedef logic [15:0] instr_t;    // {op[15:12], rd[11:9], rs1[8:6], rs2[5:3] | imm[5:0]}
    typedef logic [7:0]  pc_t;       // Word address into instruction memory
    typedef logic [2:0]  reg_idx_t;  // One of eight registers
    typedef logic [7:0]  seq_t;      // Fetch order tag, wraps
    typedef logic [15:0] stamp_t;    // Trace cycle stamp

    // Opcode field values
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_ADDI = 4'd5,  // rd = rs1 + imm
        OP_LW   = 4'd6,  // rd = mem[rs1 + imm]
        OP_SW   = 4'd7,  // mem[rs1 + imm] = rd
        OP_BEQ  = 4'd8   // if (rd == rs1) pc = pc + 1 + imm
    } opcode_e;

    // Hazard control record of the previous cycle
    typedef enum logic [1:0] {
        RUN        = 2'd0,
        LOAD_STALL = 2'd1,
        REDIRECT   = 2'd2
    } ctrl_state_e;

    ////////////////////////////////////////
    // Default sizes
    ////////////////////////////////////////
    localparam int IMEM_DEPTH  = 256;
    localparam int DMEM_DEPTH  = 64;
    localparam int TRACE_DEPTH = 8;   // Power of two, at least 8

endpackage
